// File: test/testdata.txt
// @00 program ROM, @20 initial data RAM words, @30 RAM word count then record count
// records from @32: flags (bit0 write-back, bit1 store, bit2 load) nextFetch wbValue storeIdx storeData
@00
8C010000 8C020004 8C030008 8C04000C // lw r1..r4 from words 0..3
00222820 00223022 00813824 00814025 // add r5, sub r6, and r7, or r8
0061482A 0023502A AC050010 8C0B0010 // slt r9, slt r10, sw r5, lw r11
00220020 00026020 10220005 10AB0002 // add r0, add r12, beq not taken, beq taken
00216820 00216820 08000015 00216820 // skipped, skipped, j 0x54, skipped
00216820 0C000018 00216820 00216820 // skipped, jal 0x60, skipped, skipped
03E07020 AC0E0014 8C0F0014 0800001B // add r14 from r31, sw r14, lw r15, j self
@20
00000007 00000005 FFFFFFF0 0000FF3C
@30
00000004 00000016
@32
5 00000004 00000007 0 00000000 // lw r1
5 00000008 00000005 0 00000000 // lw r2
5 0000000C FFFFFFF0 0 00000000 // lw r3, negative
5 00000010 0000FF3C 0 00000000 // lw r4
1 00000014 0000000C 0 00000000 // add r5 = 7 + 5
1 00000018 00000002 0 00000000 // sub r6 = 7 - 5
1 0000001C 00000004 0 00000000 // and r7
1 00000020 0000FF3F 0 00000000 // or r8
1 00000024 00000001 0 00000000 // slt -16 < 7
1 00000028 00000000 0 00000000 // slt 7 < -16
2 0000002C 00000000 4 0000000C // sw r5 to word 4
5 00000030 0000000C 0 00000000 // lw r11 from word 4
1 00000034 0000000C 0 00000000 // add into r0, dropped
1 00000038 00000005 0 00000000 // add r12 = r0 + r2
0 0000003C 00000000 0 00000000 // beq not taken
0 00000048 00000000 0 00000000 // beq taken
0 00000054 00000000 0 00000000 // j
1 00000060 0000005C 0 00000000 // jal links PC+8
1 00000064 0000005C 0 00000000 // add r14 = r31
2 00000068 00000000 5 0000005C // sw r14 to word 5
5 0000006C 0000005C 0 00000000 // lw r15 from word 5
0 0000006C 00000000 0 00000000 // j self

// File: sources.f
rtl/mipsPkg.sv
rtl/ctrlIf.sv
rtl/instDecoder.sv
rtl/regFile.sv
rtl/executeUnit.sv
rtl/pcUnit.sv
rtl/mipsCore.sv
test/mipsCore_checker.sv
test/mipsCoreTb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
verilator --binary --timing --assert -f sources.f --top-module mipsCoreTb -o simv \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// File: test/mipsCoreTb.sv
/* testbench for mipsCore: clock, reset, ROM and SRAM models,
   record-driven compare tasks and cycle timeout */

`timescale 1ns/1ns

module mipsCoreTb;
  import mipsPkg::*;

  // ============================================================
  // testdata layout, word offsets
  // ============================================================

  localparam int RAM_INIT_BASE = 32;
  localparam int COUNT_BASE    = 48;
  localparam int REC_BASE      = 50;

  logic                   clk;
  logic                   rst;
  word_t                  inst = '0;
  word_t                  instAddr;
  word_t                  regWriteData;
  word_t                  memReadData;
  word_t                  memWriteData;
  logic [DMEM_ADDR_W-1:0] memAddr;
  logic                   memEnableN;
  logic                   memWriteN;
  logic                   memOutputEnableN;

  word_t       testData [0:255];
  word_t       rom [0:31];
  word_t       ram [0:(1<<DMEM_ADDR_W)-1];
  int          numRecords = 0;
  int          cycleCount = 0;
  int unsigned seed;

  mipsCore mipsCore_inst (
    .clk              (clk),
    .rst              (rst),
    .inst             (inst),
    .instAddr         (instAddr),
    .regWriteData     (regWriteData),
    .memReadData      (memReadData),
    .memAddr          (memAddr),
    .memWriteData     (memWriteData),
    .memEnableN       (memEnableN),
    .memWriteN        (memWriteN),
    .memOutputEnableN (memOutputEnableN)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // synchronous fetch of the presented address
  always @(posedge clk) inst <= rom[instAddr[6:2]];

  // SRAM model, same-cycle reads
  always @(posedge clk) begin
    if (!memEnableN && !memWriteN) begin
      ram[memAddr] <= memWriteData;
    end
  end
  assign memReadData = ram[memAddr];

  // ============================================================
  // compare tasks
  // ============================================================

  task automatic reportMismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic checkWord(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      reportMismatch($sformatf("%s is %h, expected %h", what, actual, expected));
    end
  endtask

  task automatic checkLevel(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      reportMismatch($sformatf("%s is %b, expected %b", what, actual, expected));
    end
  endtask

  task automatic checkStore(input logic [DMEM_ADDR_W-1:0] actIdx, input word_t actData,
                            input logic [DMEM_ADDR_W-1:0] expIdx, input word_t expData,
                            input int rec);
    if (actIdx !== expIdx || actData !== expData) begin
      reportMismatch($sformatf("record %0d store [%0d]=%h, expected [%0d]=%h",
                               rec, actIdx, actData, expIdx, expData));
    end
  endtask

  // cycle limit from the record count
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= numRecords + 20) begin
      $display("timeout: record list not finished after %0d cycles", cycleCount);
      $display("CHECKS FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  // ============================================================
  // stimulus and checking
  // ============================================================

  initial begin
    int    ramWords;
    int    base;
    word_t flags;
    rst = 1'b0;
    seed = $urandom(79);
    $readmemh("test/testdata.txt", testData);
    for (int i = 0; i < 32; i++) begin
      rom[i] = testData[i];
    end
    ramWords   = testData[COUNT_BASE];
    numRecords = testData[COUNT_BASE+1];
    // initial words from the file, fill carries the word index
    for (int i = 0; i < (1<<DMEM_ADDR_W); i++) begin
      ram[i] = (i < ramWords) ? testData[RAM_INIT_BASE+i] : {16'ha5a5, 9'h0, i[6:0]};
    end

    repeat (8) @(posedge clk);
    checkWord(instAddr, '0, "fetch address in reset");
    rst <= 1'b1;

    // one record per executed instruction, sampled mid-cycle
    for (int r = 0; r < numRecords; r++) begin
      base  = REC_BASE + 5 * r;
      flags = testData[base];
      @(negedge clk);
      checkWord(instAddr, testData[base+1], $sformatf("record %0d fetch address", r));
      if (flags[0]) begin
        checkWord(regWriteData, testData[base+2], $sformatf("record %0d write-back", r));
      end
      checkLevel(memEnableN, ~(flags[1] | flags[2]), $sformatf("record %0d memEnableN", r));
      checkLevel(memWriteN, ~flags[1], $sformatf("record %0d memWriteN", r));
      checkLevel(memOutputEnableN, ~flags[2], $sformatf("record %0d memOutputEnableN", r));
      if (flags[1]) begin
        checkStore(memAddr, memWriteData, testData[base+3][DMEM_ADDR_W-1:0],
                   testData[base+4], r);
      end
    end

    if (mipsCore_inst.mipsCoreChecker_inst.violations == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("CHECKS FAILED");
      $fatal(1, "assertion violations on the core ports");
    end
  end

endmodule

// File: test/mipsCore_checker.sv
/* bound assertions on the mipsCore top-level ports */

`timescale 1ns/1ns

module mipsCoreChecker (
  input logic           clk,
  input logic           rst,
  input mipsPkg::word_t instAddr,
  input logic           memEnableN,
  input logic           memWriteN,
  input logic           memOutputEnableN
);

  // assertion failures seen so far
  int violations = 0;

  // a write strobe needs the chip enabled
  writeNeedsEnable: assert property (@(posedge clk) !memWriteN |-> !memEnableN)
    else begin
      violations = violations + 1;
      $error("memWriteN low while memEnableN high");
    end

  // read and write strobes are exclusive
  noReadWrite: assert property (@(posedge clk) !(!memWriteN && !memOutputEnableN))
    else begin
      violations = violations + 1;
      $error("memWriteN and memOutputEnableN low together");
    end

  // fetch is always word aligned
  fetchAligned: assert property (@(posedge clk) instAddr[1:0] == 2'b00)
    else begin
      violations = violations + 1;
      $error("instAddr not a multiple of 4");
    end

  // reset vector held during reset
  fetchInReset: assert property (@(posedge clk) !rst |-> instAddr == '0)
    else begin
      violations = violations + 1;
      $error("instAddr not zero while rst low");
    end

endmodule

bind mipsCore mipsCoreChecker mipsCoreChecker_inst (
  .clk              (clk),
  .rst              (rst),
  .instAddr         (instAddr),
  .memEnableN       (memEnableN),
  .memWriteN        (memWriteN),
  .memOutputEnableN (memOutputEnableN)
);

// File: rtl/mipsCore.sv
/* single-cycle MIPS core top: decoder, register file,
   execute unit and PC unit on plain fetch and SRAM ports */

`timescale 1ns/1ns

module mipsCore (
  input  logic                            clk,
  input  logic                            rst,
  // instruction fetch
  input  mipsPkg::word_t                  inst,
  output mipsPkg::word_t                  instAddr,
  // write-back observation
  output mipsPkg::word_t                  regWriteData,
  // SRAM data port
  input  mipsPkg::word_t                  memReadData,
  output logic [mipsPkg::DMEM_ADDR_W-1:0] memAddr,
  output mipsPkg::word_t                  memWriteData,
  output logic                            memEnableN,
  output logic                            memWriteN,
  output logic                            memOutputEnableN
);
  import mipsPkg::*;

  // ============================================================
  // internal nets
  // ============================================================

  // same bits viewed as R, I or J format
  instWord_t instView;
  word_t     rdDataA;
  word_t     rdDataB;
  word_t     wbData;
  word_t     linkAddr;
  logic      aluZero;

  assign instView = inst;

  // decoded control bundle
  ctrlIf ctrl ();

  // ============================================================
  // blocks
  // ============================================================

  instDecoder instDecoder_inst (
    .inst (instView),
    .ctrl (ctrl.dec)
  );

  // rs and rt always read, rd offered as destination
  regFile regFile_inst (
    .clk        (clk),
    .rst        (rst),
    .rdAddrA    (instView.rFmt.rs),
    .rdAddrB    (instView.rFmt.rt),
    .wrData     (wbData),
    .rdDataA    (rdDataA),
    .rdDataB    (rdDataB),
    .ctrl       (ctrl.rf),
    .rdAddrDest (instView.rFmt.rd)
  );

  executeUnit executeUnit_inst (
    .opA              (rdDataA),
    .opB              (rdDataB),
    .linkAddr         (linkAddr),
    .memReadData      (memReadData),
    .ctrl             (ctrl.exe),
    .wbData           (wbData),
    .aluZero          (aluZero),
    .memAddr          (memAddr),
    .memWriteData     (memWriteData),
    .memEnableN       (memEnableN),
    .memWriteN        (memWriteN),
    .memOutputEnableN (memOutputEnableN)
  );

  // next PC goes straight out as the fetch address
  pcUnit pcUnit_inst (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl.pc),
    .aluZero  (aluZero),
    .nextPc   (instAddr),
    .linkAddr (linkAddr)
  );

  // write-back value visible for checking
  assign regWriteData = wbData;

endmodule

// File: rtl/pcUnit.sv
/* PC register, next-PC selection and PC+8 link address */

`timescale 1ns/1ns

module pcUnit (
  input  logic           clk,
  input  logic           rst,
  ctrlIf.pc              ctrl,
  input  logic           aluZero,
  output mipsPkg::word_t nextPc,
  output mipsPkg::word_t linkAddr
);
  import mipsPkg::*;

  word_t pcReg;
  word_t pcPlus4;
  word_t jumpAddr;
  word_t branchAddr;
  word_t seqNext;
  logic  takeBranch;

  assign pcPlus4    = pcReg + 32'd4;
  // region bits of PC+4, word-aligned target
  assign jumpAddr   = {pcPlus4[31:28], ctrl.jumpTarget, 2'b00};
  // offset counted in words
  assign branchAddr = pcPlus4 + {ctrl.immExt[29:0], 2'b00};
  assign takeBranch = ctrl.branch & aluZero;

  // jump, then taken branch, then fall through
  always_comb begin
    if (ctrl.jump) begin
      seqNext = jumpAddr;
    end else if (takeBranch) begin
      seqNext = branchAddr;
    end else begin
      seqNext = pcPlus4;
    end
  end

  // fetch stays on the reset vector while rst is low
  assign nextPc = rst ? seqNext : '0;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcReg <= '0;
    end else begin
      pcReg <= nextPc;
    end
  end

  // jal return address
  assign linkAddr = pcReg + 32'd8;

endmodule

// File: rtl/executeUnit.sv
/* operand select, ALU with zero flag, write-back select
   and SRAM strobe generation */

`timescale 1ns/1ns

module executeUnit (
  input  mipsPkg::word_t                 opA,
  input  mipsPkg::word_t                 opB,
  input  mipsPkg::word_t                 linkAddr,
  input  mipsPkg::word_t                 memReadData,
  ctrlIf.exe                             ctrl,
  output mipsPkg::word_t                 wbData,
  output logic                           aluZero,
  output logic [mipsPkg::DMEM_ADDR_W-1:0] memAddr,
  output mipsPkg::word_t                 memWriteData,
  output logic                           memEnableN,
  output logic                           memWriteN,
  output logic                           memOutputEnableN
);
  import mipsPkg::*;

  word_t aluB;
  word_t aluResult;

  // ============================================================
  // ALU
  // ============================================================

  // rt data or sign-extended immediate
  assign aluB = ctrl.aluSrc ? ctrl.immExt : opB;

  always_comb begin
    case (ctrl.aluCtrl)
      ALU_AND: aluResult = opA & aluB;
      ALU_OR:  aluResult = opA | aluB;
      ALU_ADD: aluResult = opA + aluB;
      ALU_SUB: aluResult = opA - aluB;
      // signed compare, result is 0 or 1
      ALU_SLT: aluResult = ($signed(opA) < $signed(aluB)) ? 32'd1 : 32'd0;
      default: aluResult = '0;
    endcase
  end

  // beq only looks at this when branch is set
  assign aluZero = (aluResult == '0);

  // ============================================================
  // write-back and data memory
  // ============================================================

  // link first, then load data, else ALU
  always_comb begin
    if (ctrl.link) begin
      wbData = linkAddr;
    end else if (ctrl.memToReg) begin
      wbData = memReadData;
    end else begin
      wbData = aluResult;
    end
  end

  // word index, byte offset dropped
  assign memAddr      = aluResult[DMEM_ADDR_W+1:2];
  // store data is rt
  assign memWriteData = opB;

  // active-low SRAM strobes
  assign memEnableN       = ~(ctrl.memRead | ctrl.memWrite);
  assign memWriteN        = ~ctrl.memWrite;
  assign memOutputEnableN = ~ctrl.memRead;

endmodule

// File: rtl/regFile.sv
/* 32-entry register file, r0 reads as zero,
   two read ports and one write port */

`timescale 1ns/1ns

module regFile (
  input  logic              clk,
  input  logic              rst,
  input  mipsPkg::regAddr_t rdAddrA,
  input  mipsPkg::regAddr_t rdAddrB,
  input  mipsPkg::word_t    wrData,
  output mipsPkg::word_t    rdDataA,
  output mipsPkg::word_t    rdDataB,
  ctrlIf.rf                 ctrl,
  input  mipsPkg::regAddr_t rdAddrDest
);
  import mipsPkg::*;

  // storage for r1..r31 only
  word_t    regs [1:NUM_REGS-1];
  regAddr_t wrAddr;

  // destination: link wins, then rd for R type, else rt
  always_comb begin
    if (ctrl.link) begin
      wrAddr = LINK_REG;
    end else if (ctrl.regDst) begin
      wrAddr = rdAddrDest;
    end else begin
      wrAddr = rdAddrB;
    end
  end

  // write on the edge, r0 writes dropped
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.regWrite && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // combinational reads
  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

// File: rtl/instDecoder.sv
/* main control and ALU control decode, immediate sign extension
   and jump target extraction */

`timescale 1ns/1ns

module instDecoder (
  input mipsPkg::instWord_t inst,
  ctrlIf.dec                ctrl
);
  import mipsPkg::*;

  // ============================================================
  // main control from the opcode
  // ============================================================

  always_comb begin
    // safe defaults: no write, no memory access, fall through
    ctrl.regDst   = 1'b0;
    ctrl.aluSrc   = 1'b0;
    ctrl.memToReg = 1'b0;
    ctrl.regWrite = 1'b0;
    ctrl.memRead  = 1'b0;
    ctrl.memWrite = 1'b0;
    ctrl.branch   = 1'b0;
    ctrl.jump     = 1'b0;
    ctrl.link     = 1'b0;
    ctrl.aluCtrl  = ALU_NONE;

    case (inst.rFmt.opcode)
      OP_RTYPE: begin
        ctrl.regDst = 1'b1;
        // funct picks the ALU op
        case (inst.rFmt.funct)
          FN_ADD:  ctrl.aluCtrl = ALU_ADD;
          FN_SUB:  ctrl.aluCtrl = ALU_SUB;
          FN_AND:  ctrl.aluCtrl = ALU_AND;
          FN_OR:   ctrl.aluCtrl = ALU_OR;
          FN_SLT:  ctrl.aluCtrl = ALU_SLT;
          default: ctrl.aluCtrl = ALU_NONE;
        endcase
        // unsupported funct leaves the register file untouched
        ctrl.regWrite = (ctrl.aluCtrl != ALU_NONE);
      end
      OP_LW: begin
        // base + offset, result from memory
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.aluCtrl  = ALU_ADD;
      end
      OP_SW: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluCtrl  = ALU_ADD;
      end
      OP_BEQ: begin
        // equality via subtract and zero flag
        ctrl.branch  = 1'b1;
        ctrl.aluCtrl = ALU_SUB;
      end
      OP_J: begin
        ctrl.jump = 1'b1;
      end
      OP_JAL: begin
        // jump and write return address to r31
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: begin
        // unknown opcode behaves as a nop
        ctrl.aluCtrl = ALU_NONE;
      end
    endcase
  end

  // ============================================================
  // immediate and jump fields
  // ============================================================

  // sign extend the 16-bit offset
  assign ctrl.immExt = {{16{inst.iFmt.imm16[15]}}, inst.iFmt.imm16};

  // raw 26-bit target, PC unit forms the address
  assign ctrl.jumpTarget = inst.jFmt.target26;

endmodule

// File: rtl/ctrlIf.sv
/* decoded control bundle, decoder to execute, register file and PC */

`timescale 1ns/1ns

interface ctrlIf;
  import mipsPkg::*;

  // datapath steering
  logic        regDst;
  logic        aluSrc;
  logic        memToReg;
  logic        regWrite;
  // data memory access
  logic        memRead;
  logic        memWrite;
  // control flow
  logic        branch;
  logic        jump;
  logic        link;
  aluOp_t      aluCtrl;
  word_t       immExt;
  logic [25:0] jumpTarget;

  modport dec (
    output regDst, aluSrc, memToReg, regWrite, memRead, memWrite,
    output branch, jump, link, aluCtrl, immExt, jumpTarget
  );
  modport exe (input aluSrc, memToReg, memRead, memWrite, link, aluCtrl, immExt);
  modport rf  (input regDst, regWrite, link);
  modport pc  (input branch, jump, jumpTarget, immExt);

endinterface

// File: rtl/mipsPkg.sv
/* shared types for the single-cycle MIPS core: words, fields,
   instruction format union, opcode/funct codes, ALU ops, sizes */

package mipsPkg;

  // ============================================================
  // basic widths
  // ============================================================

  // data / address word
  typedef logic [31:0] word_t;

  // register index
  typedef logic [4:0] regAddr_t;

  // primary opcode field
  typedef logic [5:0] opcode_t;

  // R-format function field
  typedef logic [5:0] funct_t;

  // architectural register count, r0 included
  localparam int NUM_REGS = 32;

  // jal destination
  localparam regAddr_t LINK_REG = 5'd31;

  // data memory word index width
  localparam int DMEM_ADDR_W = 7;

  // ============================================================
  // opcode and funct codes
  // ============================================================

  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_J     = 6'h02;
  localparam opcode_t OP_JAL   = 6'h03;
  localparam opcode_t OP_BEQ   = 6'h04;
  localparam opcode_t OP_LW    = 6'h23;
  localparam opcode_t OP_SW    = 6'h2b;

  // R-type ops that the core executes
  localparam funct_t FN_ADD = 6'h20;
  localparam funct_t FN_SUB = 6'h22;
  localparam funct_t FN_AND = 6'h24;
  localparam funct_t FN_OR  = 6'h25;
  localparam funct_t FN_SLT = 6'h2a;

  // ALU operation select, classic control encoding
  typedef enum logic [3:0] {
    ALU_AND  = 4'b0000,
    ALU_OR   = 4'b0001,
    ALU_ADD  = 4'b0010,
    ALU_SUB  = 4'b0110,
    ALU_SLT  = 4'b0111,
    ALU_NONE = 4'b1111
  } aluOp_t;

  // ============================================================
  // instruction word, three views of the same 32 bits
  // ============================================================

  typedef struct packed {
    opcode_t     opcode;
    regAddr_t    rs;
    regAddr_t    rt;
    regAddr_t    rd;
    logic [4:0]  shamt;
    funct_t      funct;
  } rFmt_t;

  typedef struct packed {
    opcode_t     opcode;
    regAddr_t    rs;
    regAddr_t    rt;
    logic [15:0] imm16;
  } iFmt_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [25:0] target26;
  } jFmt_t;

  typedef union packed {
    rFmt_t rFmt;
    iFmt_t iFmt;
    jFmt_t jFmt;
  } instWord_t;

endpackage
